//--- ps2_proto_pkg.sv
package ps2_proto_pkg;

        // one data byte on the link
        typedef logic [7:0] ps2_byte_t;

        // start, eight data bits, odd parity, stop
        localparam int frame_bits = 11;

        localparam int data_bits = 8;

        // enable data reporting
        localparam ps2_byte_t cmd_enable_report = 8'hF4;

        // device answer to a good command
        localparam ps2_byte_t ack_byte = 8'hFA;

endpackage

//--- ps2_timing_pkg.sv
package ps2_timing_pkg;

        // wide enough for the inhibit delay and the idle timeout
        typedef logic [15:0] cycle_cnt_t;

        // 100 us at 50 MHz
        localparam cycle_cnt_t default_inhibit_cycles = 16'd5000;

        // equal samples before a line level is accepted
        localparam int default_filter_len = 4;

endpackage

//--- ps2_line_sync.sv
`timescale 1ns/1ps

module ps2_line_sync #(
        parameter int filter_len = ps2_timing_pkg::default_filter_len
) (
        input  logic clk,
        input  logic rstn,
        input  logic ps2_clk_in,
        input  logic ps2_data_in,
        output logic clk_s,
        output logic data_s,
        output logic clk_fall
);
        localparam int cnt_w = (filter_len > 1) ? $clog2(filter_len) : 1;
        localparam logic [cnt_w-1:0] cnt_last = cnt_w'(filter_len - 1);

        // bit 0 is the clock line, bit 1 the data line
        logic [1:0] meta_q;
        logic [1:0] sync_q;
        logic [1:0] filt_q;
        logic [1:0] flip;
        logic [cnt_w-1:0] stable_cnt [2];

        always_comb begin
                for (int i = 0; i < 2; i++) begin
                        flip[i] = (sync_q[i] != filt_q[i]) && (stable_cnt[i] == cnt_last);
                end
        end

        always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                        meta_q <= 2'b11;
                        sync_q <= 2'b11;
                        filt_q <= 2'b11;
                        stable_cnt[0] <= '0;
                        stable_cnt[1] <= '0;
                        clk_fall <= 1'b0;
                end else begin
                        meta_q <= {ps2_data_in, ps2_clk_in};
                        sync_q <= meta_q;
                        for (int i = 0; i < 2; i++) begin
                                if (sync_q[i] == filt_q[i] || flip[i]) begin
                                        stable_cnt[i] <= '0;
                                end else begin
                                        stable_cnt[i] <= stable_cnt[i] + 1'b1;
                                end
                                if (flip[i]) begin
                                        filt_q[i] <= sync_q[i];
                                end
                        end
                        // filtered clock going from high to low
                        clk_fall <= flip[0] && filt_q[0];
                end
        end

        assign clk_s  = filt_q[0];
        assign data_s = filt_q[1];

endmodule

//--- ps2_cmd_tx.sv
`timescale 1ns/1ps

module ps2_cmd_tx #(
        parameter ps2_timing_pkg::cycle_cnt_t inhibit_cycles =
                ps2_timing_pkg::default_inhibit_cycles,
        parameter ps2_proto_pkg::ps2_byte_t init_cmd =
                ps2_proto_pkg::cmd_enable_report
) (
        input  logic clk,
        input  logic rstn,
        input  logic clk_fall,
        input  logic data_s,
        output logic clk_drive_low,
        output logic data_drive_low,
        output logic done
);
        import ps2_proto_pkg::*;
        import ps2_timing_pkg::*;

        localparam int bit_w = $clog2(data_bits);
        localparam logic [bit_w-1:0] last_bit = bit_w'(data_bits - 1);

        typedef enum logic [2:0] {
                st_load,
                st_inhibit,
                st_start,
                st_shift,
                st_parity,
                st_stop,
                st_ack,
                st_finished
        } state_t;

        state_t state;
        cycle_cnt_t inhibit_cnt;
        ps2_byte_t shift_q;
        logic [bit_w-1:0] bit_cnt;
        logic parity_acc;

        always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                        state <= st_load;
                        inhibit_cnt <= '0;
                        bit_cnt <= '0;
                        parity_acc <= 1'b0;
                end else begin
                        case (state)
                                st_load: begin
                                        inhibit_cnt <= '0;
                                        bit_cnt <= '0;
                                        parity_acc <= 1'b0;
                                        state <= st_inhibit;
                                end
                                // clock held low by the host
                                st_inhibit: begin
                                        if (inhibit_cnt == inhibit_cycles) begin
                                                state <= st_start;
                                        end else begin
                                                inhibit_cnt <= inhibit_cnt + 1'b1;
                                        end
                                end
                                // request to send, device now generates the clock
                                st_start: begin
                                        if (clk_fall) begin
                                                state <= st_shift;
                                        end
                                end
                                st_shift: begin
                                        if (clk_fall) begin
                                                parity_acc <= parity_acc ^ shift_q[0];
                                                if (bit_cnt == last_bit) begin
                                                        state <= st_parity;
                                                end else begin
                                                        bit_cnt <= bit_cnt + 1'b1;
                                                end
                                        end
                                end
                                st_parity: begin
                                        if (clk_fall) begin
                                                state <= st_stop;
                                        end
                                end
                                // data released as the stop bit
                                st_stop: begin
                                        state <= st_ack;
                                end
                                // device pulls data low for one clock
                                st_ack: begin
                                        if (clk_fall && !data_s) begin
                                                state <= st_finished;
                                        end
                                end
                                default: begin
                                        state <= st_finished;
                                end
                        endcase
                end
        end

        // command byte, lsb leaves first
        always_ff @(posedge clk) begin
                if (state == st_load) begin
                        shift_q <= init_cmd;
                end else if (state == st_shift && clk_fall) begin
                        shift_q <= shift_q >> 1;
                end
        end

        always_comb begin
                clk_drive_low = (state == st_inhibit);
                case (state)
                        st_start: data_drive_low = 1'b1;
                        st_shift: data_drive_low = ~shift_q[0];
                        // odd parity bit is ~parity_acc, driven inverted
                        st_parity: data_drive_low = parity_acc;
                        default: data_drive_low = 1'b0;
                endcase
        end

        assign done = (state == st_finished);

endmodule

//--- ps2_frame_rx.sv
`timescale 1ns/1ps

module ps2_frame_rx (
        input  logic clk,
        input  logic rstn,
        input  logic enable,
        input  logic clk_fall,
        input  logic clk_s,
        input  logic data_s,
        output ps2_proto_pkg::ps2_byte_t rx_byte,
        output logic rx_valid,
        output logic rx_err
);
        import ps2_proto_pkg::*;
        import ps2_timing_pkg::*;

        localparam int cnt_w = $clog2(frame_bits);
        localparam logic [cnt_w-1:0] last_bit = cnt_w'(frame_bits - 1);
        // clock high this long inside a frame means the device gave up
        localparam cycle_cnt_t idle_limit = cycle_cnt_t'(4 * default_inhibit_cycles);

        // start bit ends up in bit 0, parity in the top bit
        logic [frame_bits-2:0] shift_q;
        logic [cnt_w-1:0] bit_cnt;
        cycle_cnt_t idle_cnt;
        logic frame_last;
        logic frame_end;
        logic start_ok;
        logic parity_ok;
        logic stop_ok;

        assign frame_last = (bit_cnt == last_bit);
        assign frame_end  = enable && clk_fall && frame_last;

        // stop bit is still on the line at the last edge
        assign start_ok  = ~shift_q[0];
        assign parity_ok = ^shift_q[frame_bits-2:1];
        assign stop_ok   = data_s;

        always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                        bit_cnt <= '0;
                        idle_cnt <= '0;
                        rx_valid <= 1'b0;
                        rx_err <= 1'b0;
                end else begin
                        rx_valid <= 1'b0;
                        rx_err <= 1'b0;
                        if (!enable) begin
                                bit_cnt <= '0;
                                idle_cnt <= '0;
                        end else if (clk_fall) begin
                                idle_cnt <= '0;
                                if (frame_end) begin
                                        bit_cnt <= '0;
                                        if (start_ok && parity_ok && stop_ok) begin
                                                rx_valid <= 1'b1;
                                        end else begin
                                                rx_err <= 1'b1;
                                        end
                                end else begin
                                        bit_cnt <= bit_cnt + 1'b1;
                                end
                        end else if (clk_s && bit_cnt != '0) begin
                                if (idle_cnt == idle_limit) begin
                                        // drop the partial frame
                                        bit_cnt <= '0;
                                        idle_cnt <= '0;
                                end else begin
                                        idle_cnt <= idle_cnt + 1'b1;
                                end
                        end else begin
                                idle_cnt <= '0;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (enable && clk_fall) begin
                        shift_q <= {data_s, shift_q[frame_bits-2:1]};
                end
                if (frame_end) begin
                        rx_byte <= shift_q[data_bits:1];
                end
        end

endmodule

//--- ps2_host.sv
`timescale 1ns/1ps

module ps2_host #(
        parameter ps2_timing_pkg::cycle_cnt_t inhibit_cycles =
                ps2_timing_pkg::default_inhibit_cycles,
        parameter int filter_len = ps2_timing_pkg::default_filter_len,
        parameter ps2_proto_pkg::ps2_byte_t init_cmd =
                ps2_proto_pkg::cmd_enable_report
) (
        input  logic clk,
        input  logic rstn,
        inout  wire  ps2_clk,
        inout  wire  ps2_data,
        output logic done,
        output ps2_proto_pkg::ps2_byte_t rx_byte,
        output logic rx_valid,
        output logic rx_err
);
        logic clk_s;
        logic data_s;
        logic clk_fall;
        logic clk_drive_low;
        logic data_drive_low;

        // open drain, the pull-ups give the high level
        assign ps2_clk  = clk_drive_low  ? 1'b0 : 1'bz;
        assign ps2_data = data_drive_low ? 1'b0 : 1'bz;

        ps2_line_sync #(
                .filter_len(filter_len)
        ) line_sync_i (
                .clk(clk),
                .rstn(rstn),
                .ps2_clk_in(ps2_clk),
                .ps2_data_in(ps2_data),
                .clk_s(clk_s),
                .data_s(data_s),
                .clk_fall(clk_fall)
        );

        ps2_cmd_tx #(
                .inhibit_cycles(inhibit_cycles),
                .init_cmd(init_cmd)
        ) cmd_tx_i (
                .clk(clk),
                .rstn(rstn),
                .clk_fall(clk_fall),
                .data_s(data_s),
                .clk_drive_low(clk_drive_low),
                .data_drive_low(data_drive_low),
                .done(done)
        );

        // receiver only listens once the command has been acknowledged
        ps2_frame_rx frame_rx_i (
                .clk(clk),
                .rstn(rstn),
                .enable(done),
                .clk_fall(clk_fall),
                .clk_s(clk_s),
                .data_s(data_s),
                .rx_byte(rx_byte),
                .rx_valid(rx_valid),
                .rx_err(rx_err)
        );

endmodule

//--- ps2_host_chk.sv
`timescale 1ns/1ps

module ps2_host_chk (
        input logic clk,
        input logic rstn,
        input logic done,
        input logic rx_valid,
        input logic rx_err,
        input wire  ps2_clk,
        input wire  ps2_data
);

        // a frame is either good or bad
        rx_excl: assert property (
                @(posedge clk) disable iff (!rstn)
                !(rx_valid && rx_err)
        ) else $error("rx_valid and rx_err were high in the same cycle");

        // done only clears on reset
        done_hold: assert property (
                @(posedge clk) disable iff (!rstn)
                done |=> done
        ) else $error("done fell while out of reset");

        // receiver stays quiet until the command is acknowledged
        rx_gated: assert property (
                @(posedge clk) disable iff (!rstn)
                !done |-> !(rx_valid || rx_err)
        ) else $error("receive pulse before done was high");

        // both lines released right after reset
        lines_idle: assert property (
                @(posedge clk)
                $rose(rstn) |-> (ps2_clk !== 1'b0 && ps2_data !== 1'b0)
        ) else $error("a PS/2 line was driven low in the first cycle after reset");

endmodule

bind ps2_host ps2_host_chk chk_i (
        .clk(clk),
        .rstn(rstn),
        .done(done),
        .rx_valid(rx_valid),
        .rx_err(rx_err),
        .ps2_clk(ps2_clk),
        .ps2_data(ps2_data)
);

//--- tb_ps2_host.sv
`timescale 1ns/1ps

module tb_ps2_host;
        import ps2_proto_pkg::*;
        import ps2_timing_pkg::*;

        localparam cycle_cnt_t inhibit_cycles = 16'd200;
        localparam int half_period = 40;
        localparam int timeout_cycles =
                2 * (int'(inhibit_cycles) + 40 * 11 * 2 * half_period) + 5000;

        logic clk;
        logic rstn;
        logic dev_clk_low;
        logic dev_data_low;
        logic cmd_done;
        wire ps2_clk;
        wire ps2_data;
        logic done;
        ps2_byte_t rx_byte;
        logic rx_valid;
        logic rx_err;
        int seed;
        int cycle_cnt;
        int matched;
        // bit 8 marks a frame that must be rejected
        logic [8:0] exp_q [$];

        pullup (ps2_clk);
        pullup (ps2_data);
        // device side of the open-drain lines
        assign ps2_clk  = dev_clk_low  ? 1'b0 : 1'bz;
        assign ps2_data = dev_data_low ? 1'b0 : 1'bz;

        ps2_host #(
                .inhibit_cycles(inhibit_cycles),
                .filter_len(4),
                .init_cmd(cmd_enable_report)
        ) dut_i (
                .clk(clk),
                .rstn(rstn),
                .ps2_clk(ps2_clk),
                .ps2_data(ps2_data),
                .done(done),
                .rx_byte(rx_byte),
                .rx_valid(rx_valid),
                .rx_err(rx_err)
        );

        task automatic fail_run(input string why);
                $display("%s", why);
                $display("Regression failed");
                $fatal(1, "run stopped at %0t ns", $time);
        endtask

        task automatic value_error(input string sig, input int expected, input int actual);
                fail_run($sformatf("[ERROR] %0t ns %s expected %0h got %0h",
                        $time, sig, expected, actual));
        endtask

        task automatic clock_low;
                dev_clk_low = 1'b1;
                repeat (half_period) @(negedge clk);
                dev_clk_low = 1'b0;
        endtask

        // inhibit, then clock in the host frame and answer with the ack bit
        task automatic accept_command;
                int low_cycles;
                ps2_byte_t cmd;
                logic par;
                logic stop;
                logic exp_par;
                low_cycles = 0;
                cmd = '0;
                par = 1'b0;
                stop = 1'b0;
                exp_par = ~(^cmd_enable_report);
                while (ps2_clk !== 1'b0) begin
                        @(negedge clk);
                end
                while (ps2_clk === 1'b0) begin
                        assert (ps2_data !== 1'b0) else value_error("ps2_data", 1, 0);
                        low_cycles++;
                        @(negedge clk);
                end
                assert (low_cycles == int'(inhibit_cycles) + 1)
                else value_error("ps2_clk low cycles", int'(inhibit_cycles) + 1, low_cycles);
                repeat (4) @(negedge clk);
                assert (ps2_data === 1'b0) else value_error("ps2_data start bit", 0, 1);
                // read each bit early in the high phase
                for (int i = 0; i < 10; i++) begin
                        clock_low();
                        repeat (2) @(negedge clk);
                        if (i < 8) begin
                                cmd[i] = (ps2_data !== 1'b0);
                        end else if (i == 8) begin
                                par = (ps2_data !== 1'b0);
                        end else begin
                                stop = (ps2_data !== 1'b0);
                        end
                        repeat (half_period / 2 - 2) @(negedge clk);
                end
                assert (cmd == cmd_enable_report)
                else value_error("command byte", int'(cmd_enable_report), int'(cmd));
                assert (par == exp_par)
                else value_error("command parity", int'(exp_par), int'(par));
                assert (stop == 1'b1) else value_error("command stop bit", 1, int'(stop));
                dev_data_low = 1'b1;
                repeat (half_period / 2) @(negedge clk);
                // ack bit takes exactly one device clock
                clock_low();
                assert (done === 1'b1)
                else fail_run("done did not rise after the acknowledge bit");
                dev_data_low = 1'b0;
        endtask

        task automatic send_frame(input ps2_byte_t value, input logic parity_ok,
                                  input logic stop_ok);
                logic [10:0] bits;
                logic par;
                int gap;
                par = ~(^value);
                if (!parity_ok) begin
                        par = ~par;
                end
                bits = {stop_ok, par, value, 1'b0};
                assert (done === 1'b1)
                else fail_run("done was low at the start of a device frame");
                exp_q.push_back({~(parity_ok && stop_ok), value});
                for (int i = 0; i < 11; i++) begin
                        dev_data_low = ~bits[i];
                        repeat (half_period / 2) @(negedge clk);
                        clock_low();
                        repeat (half_period / 2) @(negedge clk);
                end
                dev_data_low = 1'b0;
                gap = 60 + ($random(seed) & 63);
                repeat (gap) @(negedge clk);
                assert (exp_q.size() == 0)
                else fail_run("no receive pulse came for the last frame");
        endtask

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        always @(negedge clk) begin : rx_monitor
                logic [8:0] exp;
                if (cmd_done) begin
                        assert (done === 1'b1) else value_error("done", 1, int'(done));
                end
                if (rstn && (rx_valid || rx_err)) begin
                        if (exp_q.size() == 0) begin
                                fail_run("receive pulse without a frame being sent");
                        end else begin
                                exp = exp_q.pop_front();
                                if (exp[8]) begin
                                        assert (rx_err === 1'b1)
                                        else value_error("rx_err", 1, int'(rx_err));
                                        assert (rx_valid === 1'b0)
                                        else value_error("rx_valid", 0, int'(rx_valid));
                                end else begin
                                        assert (rx_valid === 1'b1)
                                        else value_error("rx_valid", 1, int'(rx_valid));
                                        assert (rx_err === 1'b0)
                                        else value_error("rx_err", 0, int'(rx_err));
                                        assert (rx_byte === exp[7:0])
                                        else value_error("rx_byte", int'(exp[7:0]), int'(rx_byte));
                                        matched++;
                                end
                        end
                end
        end

        initial begin
                cycle_cnt = 0;
                while (cycle_cnt < timeout_cycles) begin
                        @(posedge clk);
                        cycle_cnt++;
                end
                fail_run("timeout, the run did not finish in time");
        end

        initial begin
                seed = 98926;
                matched = 0;
                cmd_done = 1'b0;
                dev_clk_low = 1'b0;
                dev_data_low = 1'b0;
                rstn = 1'b0;
                repeat (10) @(negedge clk);
                rstn = 1'b1;
                accept_command();
                cmd_done = 1'b1;
                repeat (100) @(negedge clk);
                send_frame(ack_byte, 1'b1, 1'b1);
                for (int i = 0; i < 30; i++) begin
                        // bad frames in between, each followed by a good one
                        if (i == 7 || i == 19) begin
                                send_frame(ps2_byte_t'($random(seed)), 1'b0, 1'b1);
                        end
                        if (i == 12 || i == 25) begin
                                send_frame(ps2_byte_t'($random(seed)), 1'b1, 1'b0);
                        end
                        send_frame(ps2_byte_t'($random(seed)), 1'b1, 1'b1);
                end
                if (matched == 31 && exp_q.size() == 0) begin
                        $display("Regression passed");
                        $finish;
                end else begin
                        fail_run($sformatf("only %0d of 31 good bytes were received", matched));
                end
        end

endmodule

//--- list.f
ps2_proto_pkg.sv
ps2_timing_pkg.sv
ps2_line_sync.sv
ps2_cmd_tx.sv
ps2_frame_rx.sv
ps2_host.sv
ps2_host_chk.sv
tb_ps2_host.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_ps2_host
RTL_TOP    ?= ps2_host
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
RTL_SRCS   ?= ps2_proto_pkg.sv ps2_timing_pkg.sv ps2_line_sync.sv \
              ps2_cmd_tx.sv ps2_frame_rx.sv ps2_host.sv

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Regression passed" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
